// ==== cop_pkg.sv ====
package cop_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL = 3'b001;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_XOR = 3'b100;
    localparam logic [2:0] FUNCT3_SRL = 3'b101;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;
    localparam logic [6:0] FUNCT7_SLL = 7'b0000000;
    localparam logic [6:0] FUNCT7_SLT = 7'b0000000;
    localparam logic [6:0] FUNCT7_XOR = 7'b0000000;
    localparam logic [6:0] FUNCT7_SRL = 7'b0000000;
    localparam logic [6:0] FUNCT7_OR  = 7'b0000000;
    localparam logic [6:0] FUNCT7_AND = 7'b0000000;

    localparam logic [3:0] EXC_ILLEGAL_INSTR = 4'd2;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // Opcode field is {funct7, funct3, major}
    typedef struct packed {
        logic [31:0] pc;
        logic [16:0] opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } cop_slot_t;

    typedef struct packed {
        logic    legal;
        alu_op_e alu_op;
        logic    use_imm;
    } cop_op_t;

    typedef struct packed {
        logic        accept;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
    } cop_check_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        reg_w_en;
        logic [4:0]  reg_w_rd;
        logic [31:0] reg_w_data;
        logic        exc_en;
        logic [3:0]  exc_code;
    } cop_result_t;

    function automatic logic is_legal_opcode(input logic [16:0] opcode);
        logic [6:0] funct7;
        logic [2:0] funct3;
        logic [6:0] major;
        logic       legal;
        funct7 = opcode[16:10];
        funct3 = opcode[9:7];
        major  = opcode[6:0];
        legal  = 1'b0;
        if (major == OPC_OP) begin
            case ({funct7, funct3})
                {FUNCT7_ADD, FUNCT3_ADD},
                {FUNCT7_SUB, FUNCT3_SUB},
                {FUNCT7_AND, FUNCT3_AND},
                {FUNCT7_OR,  FUNCT3_OR},
                {FUNCT7_XOR, FUNCT3_XOR},
                {FUNCT7_SLL, FUNCT3_SLL},
                {FUNCT7_SRL, FUNCT3_SRL},
                {FUNCT7_SLT, FUNCT3_SLT}: legal = 1'b1;
                default:                  legal = 1'b0;
            endcase
        end else if (major == OPC_OP_IMM) begin
            // funct7 bits belong to the immediate here
            case (funct3)
                FUNCT3_ADD, FUNCT3_XOR, FUNCT3_OR, FUNCT3_AND: legal = 1'b1;
                default:                                       legal = 1'b0;
            endcase
        end
        return legal;
    endfunction

endpackage

// ==== cop_decode.sv ====
`timescale 1ns/1ns

module cop_decode import cop_pkg::*; (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        hold,
    input  logic        flush,
    input  logic [16:0] check_opcode,
    input  cop_slot_t   ready_slot,
    output logic        accept,
    output cop_op_t     exec_op
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [6:0] major;
    cop_op_t    ready_op;

    // Check stage answer
    assign accept = is_legal_opcode(check_opcode);

    assign funct7 = ready_slot.opcode[16:10];
    assign funct3 = ready_slot.opcode[9:7];
    assign major  = ready_slot.opcode[6:0];

    always_comb begin
        ready_op.legal   = is_legal_opcode(ready_slot.opcode);
        ready_op.use_imm = (major == OPC_OP_IMM);
        case (funct3)
            FUNCT3_ADD: begin
                // SUB only exists as an R-type
                if (major == OPC_OP && funct7 == FUNCT7_SUB) begin
                    ready_op.alu_op = ALU_SUB;
                end else begin
                    ready_op.alu_op = ALU_ADD;
                end
            end
            FUNCT3_SLL: ready_op.alu_op = ALU_SLL;
            FUNCT3_SLT: ready_op.alu_op = ALU_SLT;
            FUNCT3_XOR: ready_op.alu_op = ALU_XOR;
            FUNCT3_SRL: ready_op.alu_op = ALU_SRL;
            FUNCT3_OR:  ready_op.alu_op = ALU_OR;
            FUNCT3_AND: ready_op.alu_op = ALU_AND;
            default:    ready_op.alu_op = ALU_ADD;
        endcase
    end

    // Moves with the exec slot
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            exec_op <= '0;
        end else if (flush) begin
            exec_op <= '0;
        end else if (!hold) begin
            exec_op <= ready_op;
        end
    end

endmodule

// ==== cop_exec.sv ====
`timescale 1ns/1ns

module cop_exec import cop_pkg::*; (
    input  cop_op_t     exec_op,
    input  cop_slot_t   exec_slot,
    input  logic        allow,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output cop_result_t result
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_out;
    logic        valid;
    logic        exc_en;

    assign op_a  = rs1_data;
    assign op_b  = exec_op.use_imm ? exec_slot.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (exec_op.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLL: alu_out = op_a << shamt;
            ALU_SRL: alu_out = op_a >> shamt;
            ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_out = 32'd0;
        endcase
    end

    // Illegal ops only trap once the core allows them
    assign valid  = allow & exec_op.legal;
    assign exc_en = allow & ~exec_op.legal;

    always_comb begin
        result.valid      = valid;
        result.pc         = exec_slot.pc;
        result.reg_w_en   = valid & (exec_slot.rd != 5'd0);
        result.reg_w_rd   = exec_slot.rd;
        result.reg_w_data = alu_out;
        result.exc_en     = exc_en;
        result.exc_code   = exc_en ? EXC_ILLEGAL_INSTR : 4'd0;
    end

endmodule

// ==== cop_mini.sv ====
`timescale 1ns/1ns

module cop_mini import cop_pkg::*; (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        hold,
    input  logic        flush,
    input  cop_slot_t   check_slot,
    input  cop_slot_t   ready_slot,
    input  cop_slot_t   exec_slot,
    input  logic        allow,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        accept,
    output cop_result_t result
);

    cop_op_t exec_op;

    cop_decode u_decode (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .hold         (hold),
        .flush        (flush),
        .check_opcode (check_slot.opcode),
        .ready_slot   (ready_slot),
        .accept       (accept),
        .exec_op      (exec_op)
    );

    cop_exec u_exec (
        .exec_op   (exec_op),
        .exec_slot (exec_slot),
        .allow     (allow),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .result    (result)
    );

endmodule

// ==== cop_top.sv ====
`timescale 1ns/1ns

module cop_top import cop_pkg::*; (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        stall,
    input  logic        mem_wait,
    input  cop_slot_t   in_slot,
    input  logic        allow,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output cop_check_t  check,
    output cop_result_t result
);

    // Index 0 check, 1 ready, 2 exec
    cop_slot_t [2:0] stage_q;
    logic            allow_q;
    logic [31:0]     rs1_data_q;
    logic [31:0]     rs2_data_q;
    logic            hold;
    logic            accept;

    assign hold = stall | mem_wait;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            stage_q    <= '0;
            allow_q    <= 1'b0;
            rs1_data_q <= 32'd0;
            rs2_data_q <= 32'd0;
        end else if (flush) begin
            stage_q    <= '0;
            allow_q    <= 1'b0;
            rs1_data_q <= 32'd0;
            rs2_data_q <= 32'd0;
        end else if (!hold) begin
            stage_q    <= {stage_q[1:0], in_slot};
            // Operands belong to the slot entering exec
            allow_q    <= allow;
            rs1_data_q <= rs1_data;
            rs2_data_q <= rs2_data;
        end
    end

    always_comb begin
        check.accept = accept;
        check.pc     = stage_q[0].pc;
        check.rd     = stage_q[0].rd;
        check.rs1    = stage_q[0].rs1;
        check.rs2    = stage_q[0].rs2;
    end

    cop_mini u_cop (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .hold       (hold),
        .flush      (flush),
        .check_slot (stage_q[0]),
        .ready_slot (stage_q[1]),
        .exec_slot  (stage_q[2]),
        .allow      (allow_q),
        .rs1_data   (rs1_data_q),
        .rs2_data   (rs2_data_q),
        .accept     (accept),
        .result     (result)
    );

endmodule

// ==== cop_assert.sv ====
`timescale 1ns/1ns

module cop_assert import cop_pkg::*; (
    input logic        CLK,
    input logic        arst_n,
    input logic        flush,
    input logic        stall,
    input cop_check_t  check,
    input cop_result_t result
);

    property p_valid_exc_exclusive;
        @(posedge CLK) disable iff (!arst_n) !(result.valid && result.exc_en);
    endproperty

    property p_write_needs_valid;
        @(posedge CLK) disable iff (!arst_n) result.reg_w_en |-> result.valid;
    endproperty

    // Flush wins over a stall
    property p_stable_on_stall;
        @(posedge CLK) disable iff (!arst_n)
            (stall && !flush) |=> ($stable(check) && $stable(result));
    endproperty

    a_valid_exc_exclusive: assert property (p_valid_exc_exclusive)
        else $error("result.valid and result.exc_en are high together");

    a_write_needs_valid: assert property (p_write_needs_valid)
        else $error("result.reg_w_en is high without result.valid");

    a_stable_on_stall: assert property (p_stable_on_stall)
        else $error("check or result changed during a stall");

endmodule

// ==== tb_cop.sv ====
`timescale 1ns/1ns

module tb_cop import cop_pkg::*; ();

    logic        CLK;
    logic        arst_n;
    logic        flush;
    logic        stall;
    logic        mem_wait;
    logic        allow;
    cop_slot_t   in_slot;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    cop_check_t  check;
    cop_result_t result;

    integer      seed;
    int          error_count;
    logic [31:0] pc_cnt;

    cop_top uut (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .in_slot  (in_slot),
        .allow    (allow),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .check    (check),
        .result   (result)
    );

    bind cop_top cop_assert u_assert (
        .CLK    (CLK),
        .arst_n (arst_n),
        .flush  (flush),
        .stall  (stall),
        .check  (check),
        .result (result)
    );

    always #50 CLK = ~CLK;

    task automatic stop_on_error();
        error_count++;
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic tick();
        @(posedge CLK);
        @(negedge CLK);
    endtask

    // RV32I rules for the supported subset
    function automatic logic [31:0] model_alu(input logic [16:0] opcode, input logic [31:0] a,
                                              input logic [31:0] b_reg, input logic [31:0] imm);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] b;
        logic [31:0] r;
        f7 = opcode[16:10];
        f3 = opcode[9:7];
        b  = (opcode[6:0] == 7'b0010011) ? imm : b_reg;
        case (f3)
            3'b000:  r = (opcode[6:0] == 7'b0110011 && f7 == 7'b0100000) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = a >> b[4:0];
            3'b110:  r = a | b;
            3'b111:  r = a & b;
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic cop_slot_t make_slot(input logic [31:0] pc, input logic [16:0] opcode,
                                            input logic [4:0] rd, input logic [31:0] imm);
        cop_slot_t s;
        s.pc     = pc;
        s.opcode = opcode;
        s.rd     = rd;
        s.rs1    = rd ^ 5'd7;
        s.rs2    = rd ^ 5'd19;
        s.imm    = imm;
        return s;
    endfunction

    task automatic hold_for(input int cycles, input logic use_mem_wait);
        cop_check_t  check_snap;
        cop_result_t result_snap;
        stall       = !use_mem_wait;
        mem_wait    = use_mem_wait;
        check_snap  = check;
        result_snap = result;
        repeat (cycles) begin
            tick();
            assert (check === check_snap && result === result_snap) else begin
                $display("Outputs changed while the pipeline was held");
                stop_on_error();
            end
        end
        stall    = 1'b0;
        mem_wait = 1'b0;
    endtask

    task automatic wait_result(output int edges);
        edges = 0;
        do begin
            tick();
            edges++;
        end while (!(result.valid || result.exc_en) && edges < 20);
        assert (result.valid || result.exc_en) else begin
            $display("Timeout: no result.valid or exc_en after %0d cycles", edges);
            stop_on_error();
        end
    endtask

    // hold_stage picks where a hold is inserted, -1 for none
    task automatic run_instr(input cop_slot_t slot, input logic exp_accept, input logic allow_v,
                             input logic [31:0] a, input logic [31:0] b, input int hold_stage,
                             input int hold_cycles, input logic use_mem_wait,
                             output cop_result_t res);
        int edges;
        in_slot = slot;
        if (hold_stage == 0) hold_for(hold_cycles, use_mem_wait);
        tick();
        check_val("check.accept", 32'(check.accept), 32'(exp_accept));
        check_val("check.pc", check.pc, slot.pc);
        check_val("check.rd", 32'(check.rd), 32'(slot.rd));
        check_val("check.rs1", 32'(check.rs1), 32'(slot.rs1));
        check_val("check.rs2", 32'(check.rs2), 32'(slot.rs2));
        in_slot = '0;
        if (hold_stage == 1) hold_for(hold_cycles, use_mem_wait);
        tick();
        // Now in ready, core supplies operands
        allow    = allow_v;
        rs1_data = a;
        rs2_data = b;
        if (hold_stage == 2) hold_for(hold_cycles, use_mem_wait);
        if (allow_v) begin
            wait_result(edges);
            check_val("unheld edges from ready to exec", 32'(edges), 32'd1);
        end else begin
            tick();
        end
        res      = result;
        allow    = 1'b0;
        rs1_data = 32'd0;
        rs2_data = 32'd0;
    endtask

    task automatic check_result(input cop_result_t res, input logic exp_valid,
                                input cop_slot_t slot, input logic [31:0] exp_data,
                                input logic exp_exc);
        check_val("result.valid", 32'(res.valid), 32'(exp_valid));
        check_val("result.exc_en", 32'(res.exc_en), 32'(exp_exc));
        check_val("result.exc_code", 32'(res.exc_code), exp_exc ? 32'd2 : 32'd0);
        check_val("result.reg_w_en", 32'(res.reg_w_en), 32'(exp_valid && slot.rd != 5'd0));
        if (exp_valid || exp_exc) begin
            check_val("result.pc", res.pc, slot.pc);
        end
        if (exp_valid) begin
            check_val("result.reg_w_rd", 32'(res.reg_w_rd), 32'(slot.rd));
            check_val("result.reg_w_data", res.reg_w_data, exp_data);
        end
    endtask

    task automatic test_reset();
        check_val("check.accept", 32'(check.accept), 32'd0);
        check_val("result.valid", 32'(result.valid), 32'd0);
        check_val("result.reg_w_en", 32'(result.reg_w_en), 32'd0);
        check_val("result.exc_en", 32'(result.exc_en), 32'd0);
    endtask

    task automatic test_r_type();
        logic [9:0]  f;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        cop_slot_t   s;
        cop_result_t res;
        for (int i = 0; i < 8; i++) begin
            case (i)
                0:       f = {7'h00, 3'b000};
                1:       f = {7'h20, 3'b000};
                2:       f = {7'h00, 3'b111};
                3:       f = {7'h00, 3'b110};
                4:       f = {7'h00, 3'b100};
                5:       f = {7'h00, 3'b001};
                6:       f = {7'h00, 3'b101};
                default: f = {7'h00, 3'b010};
            endcase
            a      = $random(seed);
            b      = $random(seed);
            // rd of zero must not write back
            rd     = (i == 3) ? 5'd0 : 5'($random(seed)) | 5'd1;
            pc_cnt = pc_cnt + 32'd4;
            s      = make_slot(pc_cnt, {f, OPC_OP}, rd, $random(seed));
            run_instr(s, 1'b1, 1'b1, a, b, -1, 0, 1'b0, res);
            check_result(res, 1'b1, s, model_alu(s.opcode, a, b, s.imm), 1'b0);
        end
    endtask

    task automatic test_i_type();
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] a;
        cop_slot_t   s;
        cop_result_t res;
        for (int i = 0; i < 4; i++) begin
            case (i)
                0:       f3 = 3'b000;
                1:       f3 = 3'b100;
                2:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            imm    = $random(seed);
            imm    = {{20{imm[11]}}, imm[11:0]};
            a      = $random(seed);
            pc_cnt = pc_cnt + 32'd4;
            s      = make_slot(pc_cnt, {imm[11:5], f3, OPC_OP_IMM}, 5'd10 + 5'(i), imm);
            run_instr(s, 1'b1, 1'b1, a, $random(seed), -1, 0, 1'b0, res);
            check_result(res, 1'b1, s, model_alu(s.opcode, a, 32'd0, imm), 1'b0);
        end
    endtask

    task automatic test_illegal();
        cop_slot_t   s;
        cop_result_t res;
        // Load word, outside the subset
        pc_cnt = pc_cnt + 32'd4;
        s      = make_slot(pc_cnt, {7'h00, 3'b010, 7'b0000011}, 5'd5, 32'd0);
        run_instr(s, 1'b0, 1'b1, 32'd1, 32'd2, -1, 0, 1'b0, res);
        check_result(res, 1'b0, s, 32'd0, 1'b1);
        // R-type AND with a SUB funct7
        pc_cnt = pc_cnt + 32'd4;
        s      = make_slot(pc_cnt, {7'h20, 3'b111, OPC_OP}, 5'd6, 32'd0);
        run_instr(s, 1'b0, 1'b1, 32'd3, 32'd4, -1, 0, 1'b0, res);
        check_result(res, 1'b0, s, 32'd0, 1'b1);
        // Legal ADD that the core does not allow
        pc_cnt = pc_cnt + 32'd4;
        s      = make_slot(pc_cnt, {7'h00, 3'b000, OPC_OP}, 5'd7, 32'd0);
        run_instr(s, 1'b1, 1'b0, 32'd5, 32'd6, -1, 0, 1'b0, res);
        check_result(res, 1'b0, s, 32'd0, 1'b0);
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        logic [31:0] b;
        cop_slot_t   s;
        cop_result_t res;
        for (int i = 0; i < 3; i++) begin
            a      = $random(seed);
            b      = $random(seed);
            pc_cnt = pc_cnt + 32'd4;
            s      = make_slot(pc_cnt, {(i == 1) ? 7'h20 : 7'h00, 3'b000, OPC_OP}, 5'd9, 32'd0);
            run_instr(s, 1'b1, 1'b1, a, b, i, 3 + i, (i == 1), res);
            check_result(res, 1'b1, s, model_alu(s.opcode, a, b, s.imm), 1'b0);
        end
    endtask

    task automatic test_flush();
        cop_slot_t   s;
        cop_result_t res;
        pc_cnt  = pc_cnt + 32'd4;
        in_slot = make_slot(pc_cnt, {7'h00, 3'b110, OPC_OP}, 5'd3, 32'd0);
        tick();
        pc_cnt  = pc_cnt + 32'd4;
        in_slot = make_slot(pc_cnt, {7'h00, 3'b000, 7'b0000011}, 5'd4, 32'd0);
        tick();
        // Legal ADD waiting, OR then load allowed into exec
        pc_cnt  = pc_cnt + 32'd4;
        in_slot = make_slot(pc_cnt, {7'h00, 3'b000, OPC_OP}, 5'd2, 32'd0);
        allow   = 1'b1;
        flush   = 1'b1;
        for (int i = 0; i < 4; i++) begin
            tick();
            if (i == 1) begin
                in_slot = '0;
                allow   = 1'b0;
                flush   = 1'b0;
            end
            check_val("check.accept", 32'(check.accept), 32'd0);
            check_val("result.valid", 32'(result.valid), 32'd0);
            check_val("result.exc_en", 32'(result.exc_en), 32'd0);
        end
        pc_cnt = pc_cnt + 32'd4;
        s      = make_slot(pc_cnt, {7'h00, 3'b100, OPC_OP}, 5'd8, 32'd0);
        run_instr(s, 1'b1, 1'b1, 32'h0f0f_0f0f, 32'h00ff_00ff, -1, 0, 1'b0, res);
        check_result(res, 1'b1, s,
                     model_alu(s.opcode, 32'h0f0f_0f0f, 32'h00ff_00ff, 32'd0), 1'b0);
    endtask

    initial begin
        #2000000;
        $display("Simulation watchdog expired before the tests finished");
        stop_on_error();
    end

    initial begin
        seed        = 32'h99e93b94;
        error_count = 0;
        pc_cnt      = 32'h0000_1000;
        CLK         = 1'b0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        stall       = 1'b0;
        mem_wait    = 1'b0;
        allow       = 1'b0;
        in_slot     = '0;
        rs1_data    = 32'd0;
        rs2_data    = 32'd0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        test_reset();
        test_r_type();
        test_i_type();
        test_illegal();
        test_backpressure();
        test_flush();
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
cop_pkg.sv
cop_decode.sv
cop_exec.sv
cop_mini.sv
cop_top.sv
cop_assert.sv
tb_cop.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_cop
FILELIST   = tb.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
